/* src/ex_pkg.sv */
`default_nettype none

package ex_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    // rv32i base opcodes handled here
    localparam logic [6:0] OPC_R     = 7'b0110011;
    localparam logic [6:0] OPC_I     = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } alu_op_e;

    // one instruction word, four format views
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i;
        struct packed {
            logic [6:0]            imm_hi;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm_lo;
            logic [6:0]            opcode;
        } s;
        struct packed {
            logic [19:0]           imm20;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } u;
    } inst_u;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        inst_u           inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        inst_u                 inst;
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        logic [XLEN-1:0]       rs2_data;
        logic [REG_ADDR_W-1:0] rd;
    } idex_pkt_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        inst_u                 inst;
        logic [XLEN-1:0]       result; // also dmem address
        logic [XLEN-1:0]       rs2_data;
        logic [REG_ADDR_W-1:0] rd;
    } exmem_pkt_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } wb_pkt_t;

endpackage

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  ex_pkg::wb_pkt_t                     wb_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0]       rs1_addr_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0]       rs2_addr_i,
    output logic [ex_pkg::XLEN-1:0]             rs1_data_o,
    output logic [ex_pkg::XLEN-1:0]             rs2_data_o
);

    // x0 has no storage
    logic [ex_pkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int n = 1; n < 32; n++) begin
                regs[n] <= '0;
            end
        end else if (wb_i.we && (wb_i.addr != '0)) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // same-cycle read returns the old value
    always_comb begin
        rs1_data_o = '0;
        rs2_data_o = '0;
        if (rs1_addr_i != '0) rs1_data_o = regs[rs1_addr_i];
        if (rs2_addr_i != '0) rs2_data_o = regs[rs2_addr_i];
    end

endmodule

`default_nettype wire

/* src/decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  ex_pkg::fetch_pkt_t            fetch_i,
    input  logic [ex_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [ex_pkg::XLEN-1:0]       rs2_data_i,
    output logic [ex_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [ex_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    output ex_pkg::idex_pkt_t             idex_o
);

    ex_pkg::inst_u           inst;
    logic [ex_pkg::XLEN-1:0] imm;
    logic [ex_pkg::XLEN-1:0] op1;
    logic [ex_pkg::XLEN-1:0] op2;

    assign inst = fetch_i.inst;

    assign rs1_addr_o = inst.r.rs1;
    assign rs2_addr_o = inst.r.rs2;

    // immediate by format
    always_comb begin
        case (inst.r.opcode)
            ex_pkg::OPC_I, ex_pkg::OPC_LOAD: begin
                imm = {{20{inst.i.imm12[11]}}, inst.i.imm12};
            end
            ex_pkg::OPC_STORE: begin
                imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            end
            ex_pkg::OPC_LUI, ex_pkg::OPC_AUIPC: begin
                imm = {inst.u.imm20, 12'b0};
            end
            default: imm = '0;
        endcase
    end

    always_comb begin
        op1 = rs1_data_i;
        op2 = imm;
        case (inst.r.opcode)
            ex_pkg::OPC_R:     op2 = rs2_data_i;
            ex_pkg::OPC_LUI:   op1 = '0;
            ex_pkg::OPC_AUIPC: op1 = fetch_i.pc;
            default: ;         // rs1 + imm
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            idex_o    <= '0;
            idex_o.pc <= ex_pkg::RESET_PC;
        end else begin
            idex_o.valid    <= fetch_i.valid;
            idex_o.pc       <= fetch_i.pc;
            idex_o.inst     <= inst;
            idex_o.op1      <= op1;
            idex_o.op2      <= op2;
            idex_o.rs2_data <= rs2_data_i; // store data
            idex_o.rd       <= inst.r.rd;
        end
    end

endmodule

`default_nettype wire

/* src/alu_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_ctrl (
    input  ex_pkg::inst_u   inst_i,
    output ex_pkg::alu_op_e alu_op_o
);

    logic is_r;
    logic alt; // funct7 bit 5

    assign is_r = (inst_i.r.opcode == ex_pkg::OPC_R);
    assign alt  = inst_i.r.funct7[5];

    always_comb begin
        alu_op_o = ex_pkg::ADD;
        case (inst_i.r.opcode)
            ex_pkg::OPC_R, ex_pkg::OPC_I: begin
                case (inst_i.r.funct3)
                    3'b000: alu_op_o = (is_r && alt) ? ex_pkg::SUB : ex_pkg::ADD;
                    3'b001: alu_op_o = ex_pkg::SLL;
                    3'b010: alu_op_o = ex_pkg::SLT;
                    3'b011: alu_op_o = ex_pkg::SLTU;
                    3'b100: alu_op_o = ex_pkg::XOR;
                    3'b101: alu_op_o = alt ? ex_pkg::SRA : ex_pkg::SRL;
                    3'b110: alu_op_o = ex_pkg::OR;
                    3'b111: alu_op_o = ex_pkg::AND;
                    default: alu_op_o = ex_pkg::ADD;
                endcase
            end
            // lui, auipc, load, store all add
            default: alu_op_o = ex_pkg::ADD;
        endcase
    end

endmodule

`default_nettype wire

/* src/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  logic [ex_pkg::XLEN-1:0] a_i,
    input  logic [ex_pkg::XLEN-1:0] b_i,
    input  ex_pkg::alu_op_e         op_i,
    output logic [ex_pkg::XLEN-1:0] result_o
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b_i[4:0];
    assign lt_s  = ($signed(a_i) < $signed(b_i));
    assign lt_u  = (a_i < b_i);

    always_comb begin
        case (op_i)
            ex_pkg::ADD:  result_o = a_i + b_i;
            ex_pkg::SUB:  result_o = a_i - b_i;
            ex_pkg::SLL:  result_o = a_i << shamt;
            ex_pkg::SLT:  result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_s};
            ex_pkg::SLTU: result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_u};
            ex_pkg::XOR:  result_o = a_i ^ b_i;
            ex_pkg::SRL:  result_o = a_i >> shamt;
            ex_pkg::SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
            ex_pkg::OR:   result_o = a_i | b_i;
            ex_pkg::AND:  result_o = a_i & b_i;
            default:      result_o = a_i + b_i; // unused encodings
        endcase
    end

endmodule

`default_nettype wire

/* src/exec_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_stage (
    input  logic               clk,
    input  logic               rst_n_i,
    input  ex_pkg::idex_pkt_t  idex_i,
    output ex_pkg::exmem_pkt_t exmem_o
);

    ex_pkg::alu_op_e         alu_op;
    logic [ex_pkg::XLEN-1:0] alu_result;

    alu_ctrl i_alu_ctrl (
        .inst_i   (idex_i.inst),
        .alu_op_o (alu_op)
    );

    alu i_alu (
        .a_i      (idex_i.op1),
        .b_i      (idex_i.op2),
        .op_i     (alu_op),
        .result_o (alu_result)
    );

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exmem_o    <= '0;
            exmem_o.pc <= ex_pkg::RESET_PC;
        end else begin
            exmem_o.valid    <= idex_i.valid;
            exmem_o.pc       <= idex_i.pc;
            exmem_o.inst     <= idex_i.inst;
            exmem_o.result   <= alu_result; // dmem addr for ld/st
            exmem_o.rs2_data <= idex_i.rs2_data;
            exmem_o.rd       <= idex_i.rd;
        end
    end

endmodule

`default_nettype wire

/* src/core_ex_top.sv */
`timescale 1ns/100ps
`default_nettype none

module core_ex_top (
    input  logic               clk,
    input  logic               rst_n_i,
    input  ex_pkg::fetch_pkt_t fetch_i,
    input  ex_pkg::wb_pkt_t    wb_i,
    output ex_pkg::exmem_pkt_t exmem_o
);

    logic [ex_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [ex_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [ex_pkg::XLEN-1:0]       rs1_data;
    logic [ex_pkg::XLEN-1:0]       rs2_data;
    ex_pkg::idex_pkt_t             idex;

    reg_file i_reg_file (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wb_i       (wb_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    decode_stage i_decode (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .fetch_i    (fetch_i),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .idex_o     (idex)
    );

    exec_stage i_exec (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .idex_i  (idex),
        .exmem_o (exmem_o)
    );

endmodule

`default_nettype wire

/* verif/ex_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_checker (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  ex_pkg::exmem_pkt_t exmem_i
);

    ex_pkg::exmem_pkt_t want_q [$];
    int                 stamp_q [$];
    int                 neg_cnt = 0;
    int                 checks  = 0;
    int                 errors  = 0;

    task automatic expect_pkt(input ex_pkg::exmem_pkt_t pkt);
        want_q.push_back(pkt);
        stamp_q.push_back(neg_cnt);
    endtask

    function automatic int pending();
        return want_q.size();
    endfunction

    task automatic compare_field(input string field, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, field, got, want);
            errors++;
        end
    endtask

    // sampled at the falling edge when outputs are stable
    always @(negedge clk_i) begin : check_output
        ex_pkg::exmem_pkt_t want;
        int                 stamp;
        neg_cnt++;
        if (rst_n_i && exmem_i.valid === 1'b1) begin
            if (want_q.size() == 0) begin
                $display("output appeared at %0t with no instruction outstanding", $time);
                errors++;
            end else begin
                want  = want_q.pop_front();
                stamp = stamp_q.pop_front();
                checks++;
                compare_field("result", exmem_i.result, want.result);
                compare_field("rd", exmem_i.rd, want.rd);
                compare_field("pc", exmem_i.pc, want.pc);
                compare_field("inst", exmem_i.inst, want.inst);
                compare_field("rs2_data", exmem_i.rs2_data, want.rs2_data);
                // one drive edge plus two stage edges
                if (neg_cnt - stamp != 3) begin
                    $display("ERROR at %0t: output came %0d cycles after fetch, expected 2",
                             $time, neg_cnt - stamp - 1);
                    errors++;
                end
            end
        end else if (exmem_i.valid !== 1'b0) begin
            $display("ERROR at %0t: valid is %b, expected 0", $time, exmem_i.valid);
            errors++;
        end
    end

endmodule

`default_nettype wire

/* verif/tb_core_ex.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_core_ex;

    logic               clk;
    logic               rst_n;
    ex_pkg::fetch_pkt_t fetch;
    ex_pkg::wb_pkt_t    wb;
    ex_pkg::exmem_pkt_t exmem;

    logic [31:0] shadow [0:31]; // register file model
    int          seed;
    int          timeouts;
    int          chk_mark;
    int          err_mark;

    core_ex_top i_dut (
        .clk     (clk),
        .rst_n_i (rst_n),
        .fetch_i (fetch),
        .wb_i    (wb),
        .exmem_o (exmem)
    );

    ex_checker i_checker (
        .clk_i   (clk),
        .rst_n_i (rst_n),
        .exmem_i (exmem)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic send_write(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        fetch.valid <= 1'b0;
        wb.we       <= 1'b1;
        wb.addr     <= addr;
        wb.data     <= data;
        if (addr != 5'd0) shadow[addr] = data; // x0 stays zero
    endtask

    task automatic send_inst(input logic [31:0] pc, input logic [31:0] inst,
                             input logic [31:0] result);
        ex_pkg::exmem_pkt_t want;
        want.valid    = 1'b1;
        want.pc       = pc;
        want.inst     = inst;
        want.result   = result;
        want.rs2_data = shadow[inst[24:20]];
        want.rd       = inst[11:7];
        @(posedge clk);
        wb.we       <= 1'b0;
        fetch.valid <= 1'b1;
        fetch.pc    <= pc;
        fetch.inst  <= inst;
        i_checker.expect_pkt(want);
    endtask

    task automatic drain_and_report(input string name);
        int n;
        @(posedge clk);
        fetch.valid <= 1'b0;
        wb.we       <= 1'b0;
        n = 0;
        while (i_checker.pending() != 0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (i_checker.pending() != 0) begin
            $display("timed out waiting for outputs in test %s", name);
            timeouts++;
        end
        $display("test %s: %0d outputs checked, %0d errors", name,
                 i_checker.checks - chk_mark, i_checker.errors - err_mark);
        chk_mark = i_checker.checks;
        err_mark = i_checker.errors;
    endtask

    initial begin
        int          fd;
        int          code;
        int          ch;
        int          bad_lines;
        logic [7:0]  tag;
        logic [31:0] a, b, c, r, res;
        logic [4:0]  rs1, rs2, rd;
        logic [2:0]  f3;
        string       name;
        seed      = 32'h0b155fd0;
        timeouts  = 0;
        chk_mark  = 0;
        err_mark  = 0;
        bad_lines = 0;
        name      = "";
        rst_n     = 1'b0;
        fetch     = '0;
        wb        = '0;
        for (int n = 0; n < 32; n++) shadow[n] = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk); // idle cycles with nothing sent
        drain_and_report("reset");

        fd = $fopen("verif/ex_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/ex_vectors.txt");
            bad_lines++;
        end else begin
            while ($fscanf(fd, " %c", tag) == 1) begin
                case (tag)
                    "#": begin
                        ch = $fgetc(fd);
                        while (ch != 10 && ch != -1) ch = $fgetc(fd);
                    end
                    "W": begin
                        code = $fscanf(fd, "%h %h", a, b);
                        if (code != 2) begin
                            $display("malformed write line in vector file");
                            bad_lines++;
                        end else begin
                            send_write(a[4:0], b);
                        end
                    end
                    "I": begin
                        code = $fscanf(fd, "%h %h %h", a, b, c);
                        if (code != 3) begin
                            $display("malformed instruction line in vector file");
                            bad_lines++;
                        end else begin
                            send_inst(a, b, c);
                        end
                    end
                    "T": begin
                        if (name != "") drain_and_report(name);
                        code = $fscanf(fd, "%s", name);
                        if (code != 1) begin
                            $display("malformed test name line in vector file");
                            bad_lines++;
                        end
                    end
                    default: begin
                        $display("unknown line type in vector file");
                        bad_lines++;
                    end
                endcase
            end
            $fclose(fd);
            if (name != "") drain_and_report(name);
        end

        // random ADD / XOR / SLTU on x20..x23
        for (int n = 0; n < 4; n++) begin
            r = $random(seed);
            send_write(5'd20 + n[4:0], r);
        end
        for (int n = 0; n < 12; n++) begin
            r   = $random(seed);
            rs1 = 5'd20 + r[1:0];
            rs2 = 5'd20 + r[3:2];
            rd  = r[8:4];
            case (r[10:9] % 3)
                0: begin
                    f3  = 3'b000;
                    res = shadow[rs1] + shadow[rs2];
                end
                1: begin
                    f3  = 3'b100;
                    res = shadow[rs1] ^ shadow[rs2];
                end
                default: begin
                    f3  = 3'b011;
                    res = (shadow[rs1] < shadow[rs2]) ? 32'd1 : 32'd0;
                end
            endcase
            send_inst(32'h8000_0200 + n * 4, {7'b0, rs2, rs1, f3, rd, ex_pkg::OPC_R}, res);
        end
        drain_and_report("random");

        $display("total: %0d outputs checked, %0d errors, %0d timeouts",
                 i_checker.checks, i_checker.errors, timeouts);
        if (i_checker.errors == 0 && timeouts == 0 && bad_lines == 0 && i_checker.checks > 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/ex_vectors.txt */
# W <reg> <data> writes a register, I <pc> <inst> <result> sends an instruction
# T <name> starts a test, numbers in hex
T rtype
W 01 00000007
W 02 fffffff0
W 03 00000003
I 80000000 00310233 fffffff3
I 80000004 40310233 ffffffed
I 80000008 00311233 ffffff80
I 8000000c 00312233 00000001
I 80000010 00313233 00000000
I 80000014 00314233 fffffff3
I 80000018 00315233 1ffffffe
I 8000001c 40315233 fffffffe
I 80000020 00316233 fffffff3
I 80000024 00317233 00000000
T itype
I 80000028 ffb08293 00000002
I 8000002c 40215313 fffffffc
I 80000030 fff0b393 00000001
T upper_mem
I 800000fc 12345437 12345000
I 80000100 00001497 80001100
I 80000104 ffc0a503 00000003
I 80000108 0020a423 0000000f
I 8000010c fe30aa23 fffffffb
T regfile
W 00 12345678
I 80000110 001065b3 00000007
I 80000114 00000613 00000000
W 03 00000064
I 80000118 001186b3 0000006b

/* all.f */
src/ex_pkg.sv
src/reg_file.sv
src/decode_stage.sv
src/alu_ctrl.sv
src/alu.sv
src/exec_stage.sv
src/core_ex_top.sv
verif/ex_checker.sv
verif/tb_core_ex.sv
